/* audio_pkg.sv */
// Shared types and constants for the two-channel audio playback controller.
// Design files refer to these by scoped name.
`default_nettype none

package audio_pkg;

	typedef logic signed [15:0] sample_t;
	typedef logic [31:0] word_t;
	typedef logic [31:0] addr_t;
	typedef logic [23:0] count_t;

	// 15 is unity gain, 0 is 1/16
	typedef logic [3:0] volume_t;

	// Read addresses
	localparam logic [3:0] REG_RATE = 4'd0;
	localparam logic [3:0] REG_BUSY = 4'd1;

	// Write addresses
	localparam logic [3:0] REG_CH0_ADDR = 4'd0;
	localparam logic [3:0] REG_CH0_COUNT = 4'd1;
	localparam logic [3:0] REG_CH0_VOL = 4'd2;
	localparam logic [3:0] REG_CH1_ADDR = 4'd4;
	localparam logic [3:0] REG_CH1_COUNT = 4'd5;
	localparam logic [3:0] REG_CH1_VOL = 4'd6;
	localparam logic [3:0] REG_RATE_W = 4'd15;

	// Set in a count write means append, clear means replace
	localparam int COUNT_APPEND_BIT = 31;

	// 100 MHz over 256 x 22050
	localparam word_t RATE_RESET = 32'd17;
	localparam volume_t VOLUME_RESET = 4'd15;

	localparam int FIFO_DEPTH = 4;
	localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);

	// Byte step between stereo words
	localparam addr_t WORD_BYTES = 32'd4;

	typedef enum logic [1:0] {
		IDLE,
		FETCH,
		WAIT_SPACE
	} chan_state_t;

endpackage

`default_nettype wire

/* audio_regs.sv */
// CPU register block. Decodes the four-phase request/ready accesses, holds
// the channel setup, volume and sample-rate registers and pulses setup strobes.
`timescale 1ns/1ps
`default_nettype none

module audio_regs (
	input wire logic i_clock,
	input wire logic i_rst_n,
	input wire logic i_request,
	input wire logic i_rw,
	input wire logic [3:0] i_address,
	input wire audio_pkg::word_t i_wdata,
	input wire logic [1:0] i_busy,
	output audio_pkg::word_t o_rdata,
	output logic o_ready,
	output logic [1:0] o_setup,
	output logic [1:0] o_setup_append,
	output audio_pkg::addr_t o_setup_address_0,
	output audio_pkg::addr_t o_setup_address_1,
	output audio_pkg::count_t o_setup_count_0,
	output audio_pkg::count_t o_setup_count_1,
	output audio_pkg::volume_t o_volume_0,
	output audio_pkg::volume_t o_volume_1,
	output audio_pkg::word_t o_output_sample_rate
);

	logic access;
	logic write;
	audio_pkg::word_t read_data;

	// New access only while ready is still low
	assign access = i_request && !o_ready;
	assign write = access && i_rw;

	always_comb begin
		read_data = '0;
		if (!i_rw) begin
			case (i_address)
				audio_pkg::REG_RATE: read_data = o_output_sample_rate;
				audio_pkg::REG_BUSY: read_data = {30'd0, i_busy};
				default: read_data = '0;
			endcase
		end
	end

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_ready <= 1'b0;
			o_setup <= 2'b00;
			o_volume_0 <= audio_pkg::VOLUME_RESET;
			o_volume_1 <= audio_pkg::VOLUME_RESET;
			o_output_sample_rate <= audio_pkg::RATE_RESET;
		end else begin
			o_setup <= 2'b00;
			if (access) begin
				o_ready <= 1'b1;
			end else if (!i_request) begin
				o_ready <= 1'b0;
			end
			if (write) begin
				case (i_address)
					audio_pkg::REG_CH0_COUNT: o_setup[0] <= 1'b1;
					audio_pkg::REG_CH1_COUNT: o_setup[1] <= 1'b1;
					audio_pkg::REG_CH0_VOL: o_volume_0 <= i_wdata[3:0];
					audio_pkg::REG_CH1_VOL: o_volume_1 <= i_wdata[3:0];
					audio_pkg::REG_RATE_W: o_output_sample_rate <= i_wdata;
					default: ;
				endcase
			end
		end
	end

	// Setup payload, qualified by the strobes above
	always_ff @(posedge i_clock) begin
		if (access) begin
			o_rdata <= read_data;
		end
		if (write) begin
			case (i_address)
				audio_pkg::REG_CH0_ADDR: o_setup_address_0 <= i_wdata;
				audio_pkg::REG_CH1_ADDR: o_setup_address_1 <= i_wdata;
				audio_pkg::REG_CH0_COUNT: begin
					o_setup_count_0 <= i_wdata[$bits(audio_pkg::count_t)-1:0];
					o_setup_append[0] <= i_wdata[audio_pkg::COUNT_APPEND_BIT];
				end
				audio_pkg::REG_CH1_COUNT: begin
					o_setup_count_1 <= i_wdata[$bits(audio_pkg::count_t)-1:0];
					o_setup_append[1] <= i_wdata[audio_pkg::COUNT_APPEND_BIT];
				end
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

/* audio_channel.sv */
// One playback channel. Fetches stereo words over DMA into a small FIFO and
// plays one volume-scaled word per sample strobe. Supports append and replace.
`timescale 1ns/1ps
`default_nettype none

module audio_channel (
	input wire logic i_clock,
	input wire logic i_rst_n,
	input wire logic i_setup,
	input wire logic i_setup_append,
	input wire audio_pkg::addr_t i_setup_address,
	input wire audio_pkg::count_t i_setup_count,
	output logic o_dma_request,
	output audio_pkg::addr_t o_dma_address,
	input wire logic i_dma_ready,
	input wire audio_pkg::word_t i_dma_rdata,
	output logic o_busy,
	input wire audio_pkg::volume_t i_volume,
	input wire logic i_output_sample_clock,
	output audio_pkg::sample_t o_sample_left,
	output audio_pkg::sample_t o_sample_right
);

	audio_pkg::chan_state_t state;
	audio_pkg::addr_t cur_address;
	audio_pkg::count_t cur_count;
	logic pend_valid;
	audio_pkg::addr_t pend_address;
	audio_pkg::count_t pend_count;
	logic drop;

	audio_pkg::word_t fifo_mem [audio_pkg::FIFO_DEPTH];
	logic [audio_pkg::FIFO_PTR_W-1:0] wr_ptr;
	logic [audio_pkg::FIFO_PTR_W-1:0] rd_ptr;
	logic [audio_pkg::FIFO_PTR_W:0] fill;
	audio_pkg::word_t head;

	logic replace;
	logic append;
	logic load_now;
	logic issue;
	logic push;
	logic pop;

	function automatic audio_pkg::sample_t scale(input audio_pkg::sample_t s,
			input audio_pkg::volume_t v);
		logic [4:0] factor;
		logic signed [21:0] product;
		factor = {1'b0, v} + 5'd1;
		product = s * $signed({1'b0, factor});
		return product[19:4];
	endfunction

	assign replace = i_setup && !i_setup_append;
	assign append = i_setup && i_setup_append;
	// Nothing left to fetch and nothing queued, so an append starts at once
	assign load_now = append && cur_count == '0 && !pend_valid;
	assign issue = state != audio_pkg::FETCH && cur_count != '0
		&& fill < audio_pkg::FIFO_DEPTH && !replace;
	assign push = state == audio_pkg::FETCH && i_dma_ready && !drop && !replace;
	assign pop = i_output_sample_clock && fill != '0;
	assign head = fifo_mem[rd_ptr];
	assign o_busy = cur_count != '0 || pend_valid || fill != '0 || o_dma_request;

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state <= audio_pkg::IDLE;
			o_dma_request <= 1'b0;
			drop <= 1'b0;
		end else begin
			case (state)
				audio_pkg::IDLE, audio_pkg::WAIT_SPACE: begin
					if (issue) begin
						state <= audio_pkg::FETCH;
						o_dma_request <= 1'b1;
					end else if (cur_count != '0 && !replace) begin
						state <= audio_pkg::WAIT_SPACE;
					end else begin
						state <= audio_pkg::IDLE;
					end
				end
				audio_pkg::FETCH: begin
					if (i_dma_ready) begin
						state <= audio_pkg::IDLE;
						o_dma_request <= 1'b0;
						drop <= 1'b0;
					end else if (replace) begin
						// Request must finish, its word belongs to the old region
						drop <= 1'b1;
					end
				end
				default: state <= audio_pkg::IDLE;
			endcase
		end
	end

	always_ff @(posedge i_clock) begin
		if (issue) begin
			o_dma_address <= cur_address;
		end
	end

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			cur_address <= '0;
			cur_count <= '0;
			pend_valid <= 1'b0;
		end else if (replace) begin
			cur_address <= i_setup_address;
			cur_count <= i_setup_count;
			pend_valid <= 1'b0;
		end else begin
			if (issue) begin
				cur_address <= cur_address + audio_pkg::WORD_BYTES;
				cur_count <= cur_count - 1'b1;
			end else if (cur_count == '0 && pend_valid) begin
				cur_address <= pend_address;
				cur_count <= pend_count;
				pend_valid <= 1'b0;
			end
			if (load_now) begin
				cur_address <= i_setup_address;
				cur_count <= i_setup_count;
			end else if (append) begin
				pend_valid <= 1'b1;
			end
		end
	end

	always_ff @(posedge i_clock) begin
		if (append && !load_now) begin
			pend_address <= i_setup_address;
			pend_count <= i_setup_count;
		end
		if (push) begin
			fifo_mem[wr_ptr] <= i_dma_rdata;
		end
	end

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill <= '0;
		end else if (replace) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10: fill <= fill + 1'b1;
				2'b01: fill <= fill - 1'b1;
				default: ;
			endcase
		end
	end

	// Empty FIFO at the strobe plays silence
	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_sample_left <= '0;
			o_sample_right <= '0;
		end else if (i_output_sample_clock) begin
			if (fill != '0) begin
				o_sample_left <= scale(head[15:0], i_volume);
				o_sample_right <= scale(head[31:16], i_volume);
			end else begin
				o_sample_left <= '0;
				o_sample_right <= '0;
			end
		end
	end

endmodule

`default_nettype wire

/* audio_dma_arbiter.sv */
// Round-robin sharing of the single DMA master port between two channels.
// The grant holds until the ready pulse that ends the transfer.
`timescale 1ns/1ps
`default_nettype none

module audio_dma_arbiter (
	input wire logic i_clock,
	input wire logic i_rst_n,
	input wire logic [1:0] i_chan_request,
	input wire audio_pkg::addr_t i_chan_address_0,
	input wire audio_pkg::addr_t i_chan_address_1,
	input wire logic i_dma_ready,
	output logic [1:0] o_chan_ready,
	output logic o_dma_request,
	output audio_pkg::addr_t o_dma_address
);

	logic grant;
	logic issue;
	logic other_waiting;

	assign issue = !o_dma_request && i_chan_request[grant];
	assign other_waiting = i_chan_request[~grant];

	// Ready goes to the granted channel only
	assign o_chan_ready[0] = i_dma_ready && o_dma_request && !grant;
	assign o_chan_ready[1] = i_dma_ready && o_dma_request && grant;

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			grant <= 1'b0;
			o_dma_request <= 1'b0;
		end else if (o_dma_request) begin
			if (i_dma_ready) begin
				o_dma_request <= 1'b0;
				if (other_waiting) begin
					grant <= ~grant;
				end
			end
		end else if (issue) begin
			o_dma_request <= 1'b1;
		end else if (other_waiting) begin
			grant <= ~grant;
		end
	end

	// Address captured with the request and held until ready
	always_ff @(posedge i_clock) begin
		if (issue) begin
			o_dma_address <= grant ? i_chan_address_1 : i_chan_address_0;
		end
	end

endmodule

`default_nettype wire

/* audio_mixer.sv */
// Registered two-channel mixer. Adds left and right samples with clamping
// to the signed 16-bit range.
`timescale 1ns/1ps
`default_nettype none

module audio_mixer (
	input wire logic i_clock,
	input wire logic i_rst_n,
	input wire audio_pkg::sample_t i_left_0,
	input wire audio_pkg::sample_t i_left_1,
	input wire audio_pkg::sample_t i_right_0,
	input wire audio_pkg::sample_t i_right_1,
	output audio_pkg::sample_t o_sample_left,
	output audio_pkg::sample_t o_sample_right
);

	function automatic audio_pkg::sample_t saturate(input audio_pkg::sample_t a,
			input audio_pkg::sample_t b);
		logic signed [16:0] sum;
		sum = a + b;
		// Overflow when the two top bits disagree
		if (sum[16] != sum[15]) begin
			return sum[16] ? 16'sh8000 : 16'sh7fff;
		end
		return sum[15:0];
	endfunction

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_sample_left <= '0;
			o_sample_right <= '0;
		end else begin
			o_sample_left <= saturate(i_left_0, i_left_1);
			o_sample_right <= saturate(i_right_0, i_right_1);
		end
	end

endmodule

`default_nettype wire

/* audio_controller.sv */
// Two-channel audio playback controller, top level. CPU register port,
// one shared DMA master and a mixed stereo output updated per sample strobe.
`timescale 1ns/1ps
`default_nettype none

module audio_controller (
	input wire logic i_clock,
	input wire logic i_rst_n,
	input wire logic i_request,
	input wire logic i_rw,
	input wire logic [3:0] i_address,
	input wire audio_pkg::word_t i_wdata,
	output audio_pkg::word_t o_rdata,
	output logic o_ready,
	output logic o_dma_request,
	output audio_pkg::addr_t o_dma_address,
	input wire logic i_dma_ready,
	input wire audio_pkg::word_t i_dma_rdata,
	input wire logic i_output_sample_clock,
	output audio_pkg::word_t o_output_sample_rate,
	output audio_pkg::sample_t o_output_sample_left,
	output audio_pkg::sample_t o_output_sample_right
);

	logic [1:0] setup;
	logic [1:0] setup_append;
	audio_pkg::addr_t setup_address [2];
	audio_pkg::count_t setup_count [2];
	audio_pkg::volume_t volume [2];
	logic [1:0] busy;
	logic [1:0] chan_request;
	logic [1:0] chan_ready;
	audio_pkg::addr_t chan_address [2];
	audio_pkg::sample_t left [2];
	audio_pkg::sample_t right [2];

	audio_regs u_regs (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.i_request(i_request),
		.i_rw(i_rw),
		.i_address(i_address),
		.i_wdata(i_wdata),
		.i_busy(busy),
		.o_rdata(o_rdata),
		.o_ready(o_ready),
		.o_setup(setup),
		.o_setup_append(setup_append),
		.o_setup_address_0(setup_address[0]),
		.o_setup_address_1(setup_address[1]),
		.o_setup_count_0(setup_count[0]),
		.o_setup_count_1(setup_count[1]),
		.o_volume_0(volume[0]),
		.o_volume_1(volume[1]),
		.o_output_sample_rate(o_output_sample_rate)
	);

	for (genvar ch = 0; ch < 2; ch++) begin : g_chan
		audio_channel u_channel (
			.i_clock(i_clock),
			.i_rst_n(i_rst_n),
			.i_setup(setup[ch]),
			.i_setup_append(setup_append[ch]),
			.i_setup_address(setup_address[ch]),
			.i_setup_count(setup_count[ch]),
			.o_dma_request(chan_request[ch]),
			.o_dma_address(chan_address[ch]),
			.i_dma_ready(chan_ready[ch]),
			.i_dma_rdata(i_dma_rdata),
			.o_busy(busy[ch]),
			.i_volume(volume[ch]),
			.i_output_sample_clock(i_output_sample_clock),
			.o_sample_left(left[ch]),
			.o_sample_right(right[ch])
		);
	end

	audio_dma_arbiter u_arbiter (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.i_chan_request(chan_request),
		.i_chan_address_0(chan_address[0]),
		.i_chan_address_1(chan_address[1]),
		.i_dma_ready(i_dma_ready),
		.o_chan_ready(chan_ready),
		.o_dma_request(o_dma_request),
		.o_dma_address(o_dma_address)
	);

	audio_mixer u_mixer (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.i_left_0(left[0]),
		.i_left_1(left[1]),
		.i_right_0(right[0]),
		.i_right_1(right[1]),
		.o_sample_left(o_output_sample_left),
		.o_sample_right(o_output_sample_right)
	);

endmodule

`default_nettype wire

/* audio_checker.sv */
// Concurrent checks on the CPU and DMA handshakes, arbitration and reset state.
// Bound into the controller top level.
`timescale 1ns/1ps
`default_nettype none

module audio_checker (
	input wire logic i_clock,
	input wire logic i_rst_n,
	input wire logic i_request,
	input wire logic i_ready,
	input wire logic i_dma_request,
	input wire audio_pkg::addr_t i_dma_address,
	input wire logic i_dma_ready,
	input wire logic [1:0] i_chan_request,
	input wire logic [1:0] i_chan_ready,
	input wire logic [1:0] i_busy,
	input wire logic [7:0] i_volume,
	input wire audio_pkg::word_t i_rate,
	input wire audio_pkg::sample_t i_left,
	input wire audio_pkg::sample_t i_right
);

	int unsigned failures = 0;
	logic last_served;
	logic other_waiting;

	// Channel served last, and whether the other one was left waiting
	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			last_served <= 1'b0;
			other_waiting <= 1'b0;
		end else if (|i_chan_ready) begin
			last_served <= i_chan_ready[1];
			other_waiting <= i_chan_ready[1] ? i_chan_request[0] : i_chan_request[1];
		end
	end

	a_ready_rise: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		i_request && !i_ready |=> i_ready)
		else begin
			failures++;
			$error("CPU ready did not rise after a request");
		end

	a_ready_fall: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		!i_request && i_ready |=> !i_ready)
		else begin
			failures++;
			$error("CPU ready did not fall after the request");
		end

	a_ready_idle: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		!i_request && !i_ready |=> !i_ready)
		else begin
			failures++;
			$error("CPU ready rose without a request");
		end

	a_dma_hold: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		i_dma_request && !i_dma_ready |=> i_dma_request && $stable(i_dma_address))
		else begin
			failures++;
			$error("DMA request or address changed before ready");
		end

	a_round_robin: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		(|i_chan_ready) && other_waiting |-> i_chan_ready[1] != last_served)
		else begin
			failures++;
			$error("DMA grant did not alternate");
		end

	a_reset_state: assert property (@(posedge i_clock)
		$rose(i_rst_n) |-> !i_ready && !i_dma_request && i_busy == 2'b00
			&& i_left == 0 && i_right == 0 && i_volume == 8'hff
			&& i_rate == audio_pkg::RATE_RESET)
		else begin
			failures++;
			$error("Outputs not in reset state");
		end

endmodule

bind audio_controller audio_checker u_checker (
	.i_clock(i_clock),
	.i_rst_n(i_rst_n),
	.i_request(i_request),
	.i_ready(o_ready),
	.i_dma_request(o_dma_request),
	.i_dma_address(o_dma_address),
	.i_dma_ready(i_dma_ready),
	.i_chan_request(chan_request),
	.i_chan_ready(chan_ready),
	.i_busy(busy),
	.i_volume({volume[1], volume[0]}),
	.i_rate(o_output_sample_rate),
	.i_left(o_output_sample_left),
	.i_right(o_output_sample_right)
);

`default_nettype wire

/* tb_audio_controller.sv */
// Testbench for the audio controller. Programs playback regions over the CPU port,
// serves DMA from a memory model and checks the mixed samples after each strobe.
`timescale 1ns/1ps
`default_nettype none

module tb_audio_controller;

	logic clock;
	logic rst_n;
	logic request;
	logic rw;
	logic [3:0] address;
	audio_pkg::word_t wdata;
	audio_pkg::word_t rdata;
	logic ready;
	logic dma_request;
	audio_pkg::addr_t dma_address;
	logic dma_ready;
	audio_pkg::word_t dma_rdata;
	logic sample_strobe;
	audio_pkg::word_t rate;
	audio_pkg::sample_t left;
	audio_pkg::sample_t right;

	int errors = 0;
	int checks = 0;
	int vol [2];
	audio_pkg::word_t data_seed;
	audio_pkg::word_t play_q [2][$];
	audio_pkg::addr_t fetch_q [2][$];

	audio_controller DUT (
		.i_clock(clock),
		.i_rst_n(rst_n),
		.i_request(request),
		.i_rw(rw),
		.i_address(address),
		.i_wdata(wdata),
		.o_rdata(rdata),
		.o_ready(ready),
		.o_dma_request(dma_request),
		.o_dma_address(dma_address),
		.i_dma_ready(dma_ready),
		.i_dma_rdata(dma_rdata),
		.i_output_sample_clock(sample_strobe),
		.o_output_sample_rate(rate),
		.o_output_sample_left(left),
		.o_output_sample_right(right)
	);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	// Memory contents are forced large and positive above bit 20 for the mix test
	function automatic audio_pkg::word_t mem_word(input audio_pkg::addr_t a);
		audio_pkg::word_t w;
		w = (a ^ data_seed) * 32'h9e3779b1;
		w = w ^ (w >> 15);
		if (a[20]) begin
			w = (w | 32'h6000_6000) & 32'h7fff_7fff;
		end
		return w;
	endfunction

	function automatic int scaled(input logic [15:0] s, input int v);
		return (int'($signed(s)) * (v + 1)) >>> 4;
	endfunction

	function automatic int clamp(input int v);
		if (v > 32767) begin
			return 32767;
		end
		if (v < -32768) begin
			return -32768;
		end
		return v;
	endfunction

	task automatic check(input string name, input int expected, input int actual);
		checks++;
		assert (expected == actual) else begin
			errors++;
			$display("Mismatch at %0t: %s expected %0d got %0d", $time, name, expected, actual);
		end
	endtask

	task automatic report_and_finish();
		int total;
		total = errors + int'(DUT.u_checker.failures);
		$display("Checks: %0d  Errors: %0d  Assertion failures: %0d", checks, errors,
			DUT.u_checker.failures);
		if (total == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	endtask

	// Four-phase access driven 1 ns after the clock edge
	task automatic cpu_access(input logic write, input logic [3:0] addr,
			input audio_pkg::word_t data, output audio_pkg::word_t rdata_out);
		int n;
		logic answered;
		n = 0;
		rw = write;
		address = addr;
		wdata = data;
		request = 1'b1;
		do begin
			@(posedge clock);
			#1;
			n++;
		end while (!ready && n < 10);
		answered = ready;
		rdata_out = rdata;
		request = 1'b0;
		do begin
			@(posedge clock);
			#1;
			n++;
		end while (ready && n < 20);
		assert (answered && !ready) else begin
			errors++;
			$display("CPU access to register %0d did not complete", addr);
		end
	endtask

	task automatic set_volume(input int ch, input int v);
		audio_pkg::word_t unused;
		vol[ch] = v;
		cpu_access(1'b1, ch ? audio_pkg::REG_CH1_VOL : audio_pkg::REG_CH0_VOL, v, unused);
	endtask

	// Expected words and fetch addresses are queued before the count write starts DMA
	task automatic program_region(input int ch, input audio_pkg::addr_t base, input int count,
			input logic append);
		audio_pkg::word_t cmd;
		audio_pkg::word_t unused;
		if (!append) begin
			play_q[ch].delete();
			fetch_q[ch].delete();
		end
		for (int i = 0; i < count; i++) begin
			play_q[ch].push_back(mem_word(base + 4 * i));
			fetch_q[ch].push_back(base + 4 * i);
		end
		cmd = 32'(count);
		cmd[audio_pkg::COUNT_APPEND_BIT] = append;
		cpu_access(1'b1, ch ? audio_pkg::REG_CH1_ADDR : audio_pkg::REG_CH0_ADDR, base, unused);
		cpu_access(1'b1, ch ? audio_pkg::REG_CH1_COUNT : audio_pkg::REG_CH0_COUNT, cmd, unused);
	endtask

	task automatic play(input int strobes);
		int exp_left;
		int exp_right;
		audio_pkg::word_t w;
		for (int n = 0; n < strobes; n++) begin
			exp_left = 0;
			exp_right = 0;
			repeat (62) @(posedge clock);
			#1;
			sample_strobe = 1'b1;
			for (int ch = 0; ch < 2; ch++) begin
				if (play_q[ch].size() > 0) begin
					w = play_q[ch].pop_front();
					exp_left += scaled(w[15:0], vol[ch]);
					exp_right += scaled(w[31:16], vol[ch]);
				end
			end
			@(posedge clock);
			#1;
			sample_strobe = 1'b0;
			// Mixer output settles two edges after the strobe
			@(posedge clock);
			#1;
			check("o_output_sample_left", clamp(exp_left), left);
			check("o_output_sample_right", clamp(exp_right), right);
		end
	endtask

	task automatic expect_idle();
		audio_pkg::word_t q;
		cpu_access(1'b0, audio_pkg::REG_BUSY, '0, q);
		check("busy bits", 0, q);
		check("channel 0 words not fetched", 0, fetch_q[0].size());
		check("channel 1 words not fetched", 0, fetch_q[1].size());
	endtask

	task automatic match_fetch(input audio_pkg::addr_t a);
		logic hit;
		hit = 1'b1;
		if (fetch_q[0].size() > 0 && fetch_q[0][0] == a) begin
			void'(fetch_q[0].pop_front());
		end else if (fetch_q[1].size() > 0 && fetch_q[1][0] == a) begin
			void'(fetch_q[1].pop_front());
		end else begin
			hit = 1'b0;
		end
		assert (hit) else begin
			errors++;
			$display("DMA fetch at %0t from address %h is out of sequence", $time, a);
		end
	endtask

	// Memory responder with 0 to 3 cycles of latency
	initial begin
		int lat;
		dma_ready = 1'b0;
		dma_rdata = '0;
		forever begin
			@(posedge clock);
			#1;
			if (dma_request) begin
				lat = $urandom % 4;
				repeat (lat) begin
					@(posedge clock);
					#1;
				end
				match_fetch(dma_address);
				dma_rdata = mem_word(dma_address);
				dma_ready = 1'b1;
				@(posedge clock);
				#1;
				dma_ready = 1'b0;
			end
		end
	end

	// 40 strobes of 64 clocks plus a margin for the CPU accesses
	initial begin
		repeat (40 * 64 + 4000) @(posedge clock);
		$display("Timeout: the run did not finish in time");
		errors++;
		report_and_finish();
	end

	initial begin
		audio_pkg::word_t q;
		audio_pkg::word_t rate_value;
		void'($urandom(32'h89a5b5ee));
		data_seed = $urandom;
		rst_n = 1'b0;
		request = 1'b0;
		rw = 1'b0;
		address = '0;
		wdata = '0;
		sample_strobe = 1'b0;
		vol[0] = 15;
		vol[1] = 15;
		repeat (10) @(posedge clock);
		#1;
		rst_n = 1'b1;

		cpu_access(1'b0, audio_pkg::REG_RATE, '0, q);
		check("rate after reset", audio_pkg::RATE_RESET, q);
		rate_value = $urandom;
		cpu_access(1'b1, audio_pkg::REG_RATE_W, rate_value, q);
		cpu_access(1'b0, audio_pkg::REG_RATE, '0, q);
		check("rate readback", rate_value, q);
		check("o_output_sample_rate", rate_value, rate);

		// One channel at unity, then at volume 7
		program_region(0, 32'h0000_1000, 6, 1'b0);
		play(8);
		expect_idle();
		set_volume(0, 7);
		program_region(0, 32'h0000_2000, 4, 1'b0);
		play(5);

		// Both channels with saturating sums
		set_volume(0, 15);
		program_region(0, 32'h0010_0000, 5, 1'b0);
		program_region(1, 32'h0013_0000, 5, 1'b0);
		play(6);
		expect_idle();

		// Append lands in the pending slot
		program_region(0, 32'h0000_3000, 8, 1'b0);
		play(2);
		program_region(0, 32'h0000_3400, 4, 1'b1);
		play(13);
		expect_idle();

		// Replace once the FIFO has refilled
		program_region(0, 32'h0000_5000, 10, 1'b0);
		play(2);
		repeat (20) @(posedge clock);
		#1;
		program_region(0, 32'h0000_6000, 3, 1'b0);
		play(4);
		expect_idle();
		report_and_finish();
	end

endmodule

`default_nettype wire

/* project.f */
audio_pkg.sv
audio_regs.sv
audio_channel.sv
audio_dma_arbiter.sv
audio_mixer.sv
audio_controller.sv
audio_checker.sv
tb_audio_controller.sv

/* Makefile */
SIM = obj_dir/Vtb_audio_controller
SOURCES = $(filter %.sv,$(shell cat project.f))

.PHONY: run clean

run: $(SIM)
	@out="$$(./$(SIM) +verilator+error+limit+100)"; echo "$$out"; \
		echo "$$out" | grep -qx 'No errors'

$(SIM): project.f $(SOURCES)
	verilator --binary --timing --assert -Wno-fatal \
		--top-module tb_audio_controller -f project.f

clean:
	rm -rf obj_dir
